//--- common/rvPkg.sv
package rvPkg;

	// data, address and instruction values
	typedef logic [31:0] word;

	typedef logic [4:0] regIdx;

	typedef enum logic [3:0] {
		aluAdd   = 4'd0,
		aluSub   = 4'd1,
		aluSll   = 4'd2,
		aluSlt   = 4'd3,
		aluSltu  = 4'd4,
		aluXor   = 4'd5,
		aluSrl   = 4'd6,
		aluSra   = 4'd7,
		aluOr    = 4'd8,
		aluAnd   = 4'd9,
		aluPassB = 4'd10
	} aluOp;

	// jump is taken unconditionally
	typedef enum logic [2:0] {
		brNone = 3'd0,
		brEq   = 3'd1,
		brNe   = 3'd2,
		brLt   = 3'd3,
		brGe   = 3'd4,
		brLtu  = 3'd5,
		brGeu  = 3'd6,
		brJump = 3'd7
	} branchKind;

	typedef enum logic [1:0] {
		wbAlu     = 2'd0,
		wbMem     = 2'd1,
		wbPcPlus4 = 2'd2
	} wbSel;

	// same encoding as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'b00,
		sizeHalf = 2'b01,
		sizeWord = 2'b10
	} accessSize;

	typedef enum logic [6:0] {
		opLui    = 7'b0110111,
		opAuipc  = 7'b0010111,
		opJal    = 7'b1101111,
		opJalr   = 7'b1100111,
		opBranch = 7'b1100011,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opImm    = 7'b0010011,
		opOp     = 7'b0110011,
		opSystem = 7'b1110011
	} opcode;

	localparam word ebreakInst = 32'h0010_0073;

endpackage

//--- hdl/pcUnit.sv
module pcUnit import rvPkg::*; #(
	parameter word resetVector = 32'h0000_0000
) (
	input  logic clk,
	input  logic rstN,
	input  logic branchTaken,
	input  word  jalrTarget,
	input  word  imm,
	input  logic halt,
	input  logic isJalr,
	output word  pc,
	output word  pcPlus4
);

	word nextPc;

	assign pcPlus4 = pc + 32'd4;

	// jalr wins over the branch adder
	always_comb begin
		if (isJalr) begin
			nextPc = {jalrTarget[31:1], 1'b0};
		end else if (branchTaken) begin
			nextPc = pc + imm;
		end else begin
			nextPc = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= resetVector;
		end else if (!halt) begin
			pc <= nextPc;
		end
	end

endmodule

//--- decode/controlDecoder.sv
module controlDecoder import rvPkg::*; (
	input  logic      rstN,
	input  word       inst,
	output aluOp      aluOperation,
	output logic      srcAIsPc,
	output logic      srcBIsImm,
	output logic      regWrite,
	output logic      memWrite,
	output logic      loadSigned,
	output logic      isJalr,
	output logic      halt,
	output branchKind branch,
	output accessSize size,
	output wbSel      writeBackSel
);

	opcode      op;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       regWriteRaw;
	logic       memWriteRaw;
	logic       shiftOk;
	logic       opOk;

	assign op = opcode'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	function automatic aluOp aluFromFunct3(input logic [2:0] f3, input logic alt);
		aluOp sel;
		case (f3)
			3'b000: sel = alt ? aluSub : aluAdd;
			3'b001: sel = aluSll;
			3'b010: sel = aluSlt;
			3'b011: sel = aluSltu;
			3'b100: sel = aluXor;
			3'b101: sel = alt ? aluSra : aluSrl;
			3'b110: sel = aluOr;
			default: sel = aluAnd;
		endcase
		return sel;
	endfunction

	// slli needs funct7 zero, srli/srai allow bit 30
	assign shiftOk = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
		(funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) : 1'b1;
	assign opOk = (funct7 == 7'b0000000) ||
		(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb begin
		// anything unmatched stays a bubble
		aluOperation = aluAdd;
		srcAIsPc = 1'b0;
		srcBIsImm = 1'b0;
		regWriteRaw = 1'b0;
		memWriteRaw = 1'b0;
		loadSigned = 1'b0;
		isJalr = 1'b0;
		halt = 1'b0;
		branch = brNone;
		size = sizeWord;
		writeBackSel = wbAlu;
		case (op)
			opLui: begin
				aluOperation = aluPassB;
				srcBIsImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opAuipc: begin
				srcAIsPc = 1'b1;
				srcBIsImm = 1'b1;
				regWriteRaw = 1'b1;
			end
			opJal: begin
				branch = brJump;
				regWriteRaw = 1'b1;
				writeBackSel = wbPcPlus4;
			end
			opJalr: begin
				if (funct3 == 3'b000) begin
					srcBIsImm = 1'b1;
					isJalr = 1'b1;
					regWriteRaw = 1'b1;
					writeBackSel = wbPcPlus4;
				end
			end
			opBranch: begin
				case (funct3)
					3'b000: branch = brEq;
					3'b001: branch = brNe;
					3'b100: branch = brLt;
					3'b101: branch = brGe;
					3'b110: branch = brLtu;
					3'b111: branch = brGeu;
					default: branch = brNone;
				endcase
			end
			opLoad: begin
				if (funct3[1:0] != 2'b11 && !(funct3[2] && funct3[1])) begin
					srcBIsImm = 1'b1;
					regWriteRaw = 1'b1;
					loadSigned = !funct3[2];
					size = accessSize'(funct3[1:0]);
					writeBackSel = wbMem;
				end
			end
			opStore: begin
				if (!funct3[2] && funct3[1:0] != 2'b11) begin
					srcBIsImm = 1'b1;
					memWriteRaw = 1'b1;
					size = accessSize'(funct3[1:0]);
				end
			end
			opImm: begin
				if (shiftOk) begin
					aluOperation = aluFromFunct3(funct3, inst[30] && funct3 == 3'b101);
					srcBIsImm = 1'b1;
					regWriteRaw = 1'b1;
				end
			end
			opOp: begin
				if (opOk) begin
					aluOperation = aluFromFunct3(funct3, inst[30]);
					regWriteRaw = 1'b1;
				end
			end
			opSystem: begin
				halt = (inst == ebreakInst);
			end
			default: begin
				halt = 1'b0;
			end
		endcase
	end

	assign regWrite = regWriteRaw && rstN && !halt;
	assign memWrite = memWriteRaw && rstN && !halt;

endmodule

//--- decode/immGenerator.sv
module immGenerator import rvPkg::*; (
	input  word inst,
	output word imm
);

	opcode op;

	assign op = opcode'(inst[6:0]);

	always_comb begin
		case (op)
			opLoad, opImm, opJalr: begin
				imm = {{20{inst[31]}}, inst[31:20]};
			end
			opStore: begin
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			// B and J formats keep bit 0 at zero
			opBranch: begin
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			opLui, opAuipc: begin
				imm = {inst[31:12], 12'b0};
			end
			opJal: begin
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

//--- hdl/registerFile.sv
module registerFile import rvPkg::*; (
	input  logic  clk,
	input  logic  rstN,
	input  regIdx rs1,
	input  regIdx rs2,
	input  regIdx rd,
	input  logic  writeEnable,
	input  word   writeData,
	output word   rs1Data,
	output word   rs2Data
);

	word regs [32];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && rd != '0) begin
			regs[rd] <= writeData;
		end
	end

	// x0 reads as zero
	assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hdl/alu.sv
module alu import rvPkg::*; (
	input  word       a,
	input  word       b,
	input  aluOp      operation,
	input  branchKind branch,
	output word       result,
	output logic      branchTaken
);

	logic [4:0] shamt;
	logic       lessSigned;
	logic       lessUnsigned;

	assign shamt = b[4:0];
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (operation)
			aluAdd:   result = a + b;
			aluSub:   result = a - b;
			aluSll:   result = a << shamt;
			aluSlt:   result = {31'b0, lessSigned};
			aluSltu:  result = {31'b0, lessUnsigned};
			aluXor:   result = a ^ b;
			aluSrl:   result = a >> shamt;
			aluSra:   result = word'($signed(a) >>> shamt);
			aluOr:    result = a | b;
			aluAnd:   result = a & b;
			aluPassB: result = b;
			default:  result = '0;
		endcase
	end

	// comparison on the register operands
	always_comb begin
		case (branch)
			brEq:    branchTaken = (a == b);
			brNe:    branchTaken = (a != b);
			brLt:    branchTaken = lessSigned;
			brGe:    branchTaken = !lessSigned;
			brLtu:   branchTaken = lessUnsigned;
			brGeu:   branchTaken = !lessUnsigned;
			brJump:  branchTaken = 1'b1;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

//--- hdl/dataMemory.sv
module dataMemory import rvPkg::*; #(
	parameter int memWords = 1024
) (
	input  logic      clk,
	input  word       address,
	input  word       storeValue,
	input  logic      writeEnable,
	input  logic      loadSigned,
	input  accessSize size,
	output word       loadData
);

	localparam int addrBits = $clog2(memWords);

	word                 mem [memWords];
	logic [addrBits-1:0] index;
	logic [3:0]          byteEnable;
	word                 laneData;
	word                 readWord;
	word                 shifted;

	// upper address bits wrap onto the array
	assign index = address[addrBits+1:2];

	always_comb begin
		case (size)
			sizeByte: begin
				byteEnable = 4'b0001 << address[1:0];
				laneData = {4{storeValue[7:0]}};
			end
			sizeHalf: begin
				byteEnable = 4'b0011 << {address[1], 1'b0};
				laneData = {2{storeValue[15:0]}};
			end
			default: begin
				byteEnable = 4'b1111;
				laneData = storeValue;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (writeEnable) begin
			for (int i = 0; i < 4; i++) begin
				if (byteEnable[i]) begin
					mem[index][i*8 +: 8] <= laneData[i*8 +: 8];
				end
			end
		end
	end

	assign readWord = mem[index];
	// move the addressed lane down to bit 0
	assign shifted = readWord >> {address[1:0], 3'b000};

	always_comb begin
		case (size)
			sizeByte: begin
				loadData = {{24{loadSigned & shifted[7]}}, shifted[7:0]};
			end
			sizeHalf: begin
				loadData = {{16{loadSigned & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				loadData = readWord;
			end
		endcase
	end

endmodule

//--- hdl/rvCore.sv
module rvCore import rvPkg::*; #(
	parameter word resetVector = 32'h0000_0000,
	parameter int  memWords    = 1024
) (
	input  logic clk,
	input  logic rstN,
	input  word  inst,
	output word  pc,
	output word  aluResult,
	output word  wbData,
	output word  storeData,
	output logic regWrite,
	output logic memWrite,
	output logic halted
);

	regIdx     rs1;
	regIdx     rs2;
	regIdx     rd;
	word       rs1Data;
	word       rs2Data;
	word       imm;
	word       pcPlus4;
	word       srcA;
	word       srcB;
	word       loadData;
	aluOp      aluOperation;
	branchKind branch;
	accessSize size;
	wbSel      writeBackSel;
	logic      srcAIsPc;
	logic      srcBIsImm;
	logic      regWriteDec;
	logic      memWriteDec;
	logic      loadSigned;
	logic      isJalr;
	logic      haltDec;
	logic      branchTaken;
	logic      haltedQ;

	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd = inst[11:7];

	// sticky until reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			haltedQ <= 1'b0;
		end else if (haltDec) begin
			haltedQ <= 1'b1;
		end
	end

	assign halted = haltDec || haltedQ;
	assign regWrite = regWriteDec && !haltedQ;
	assign memWrite = memWriteDec && !haltedQ;
	assign storeData = rs2Data;

	controlDecoder controlDecoder_i (
		.rstN         (rstN),
		.inst         (inst),
		.aluOperation (aluOperation),
		.srcAIsPc     (srcAIsPc),
		.srcBIsImm    (srcBIsImm),
		.regWrite     (regWriteDec),
		.memWrite     (memWriteDec),
		.loadSigned   (loadSigned),
		.isJalr       (isJalr),
		.halt         (haltDec),
		.branch       (branch),
		.size         (size),
		.writeBackSel (writeBackSel)
	);

	immGenerator immGenerator_i (
		.inst (inst),
		.imm  (imm)
	);

	registerFile registerFile_i (
		.clk         (clk),
		.rstN        (rstN),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.writeEnable (regWrite),
		.writeData   (wbData),
		.rs1Data     (rs1Data),
		.rs2Data     (rs2Data)
	);

	assign srcA = srcAIsPc ? pc : rs1Data;
	assign srcB = srcBIsImm ? imm : rs2Data;

	alu alu_i (
		.a           (srcA),
		.b           (srcB),
		.operation   (aluOperation),
		.branch      (branch),
		.result      (aluResult),
		.branchTaken (branchTaken)
	);

	pcUnit #(
		.resetVector (resetVector)
	) pcUnit_i (
		.clk         (clk),
		.rstN        (rstN),
		.branchTaken (branchTaken),
		.jalrTarget  (aluResult),
		.imm         (imm),
		.halt        (halted),
		.isJalr      (isJalr),
		.pc          (pc),
		.pcPlus4     (pcPlus4)
	);

	dataMemory #(
		.memWords (memWords)
	) dataMemory_i (
		.clk         (clk),
		.address     (aluResult),
		.storeValue  (rs2Data),
		.writeEnable (memWrite),
		.loadSigned  (loadSigned),
		.size        (size),
		.loadData    (loadData)
	);

	always_comb begin
		case (writeBackSel)
			wbMem:     wbData = loadData;
			wbPcPlus4: wbData = pcPlus4;
			default:   wbData = aluResult;
		endcase
	end

endmodule

//--- tb/rvCore_checker.sv
module rvCore_checker import rvPkg::*; (
	input logic clk,
	input logic rstN,
	input word  pc,
	input logic regWrite,
	input logic memWrite,
	input logic halted
);

	int failCount = 0;

	noDoubleWrite: assert property (@(posedge clk) disable iff (!rstN)
		!(regWrite && memWrite)) else begin
		failCount++;
		$error("regWrite and memWrite are high in the same cycle");
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		pc[1:0] == 2'b00) else begin
		failCount++;
		$error("pc %h is not word aligned", pc);
	end

	// pc frozen once the core has halted
	haltHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> $stable(pc)) else begin
		failCount++;
		$error("pc moved while halted");
	end

endmodule

bind rvCore rvCore_checker coreChecker_i (
	.clk      (clk),
	.rstN     (rstN),
	.pc       (pc),
	.regWrite (regWrite),
	.memWrite (memWrite),
	.halted   (halted)
);

//--- tb/rvCoreTb.sv
module rvCoreTb import rvPkg::*; ();

	localparam word resetVec = 32'h0000_0200;
	localparam int maxEntries = 64;

	logic clk;
	logic rstN;
	word  inst;
	word  pc;
	word  aluResult;
	word  wbData;
	word  storeData;
	logic regWrite;
	logic memWrite;
	logic halted;

	// stimulus table with the expected values of the reference model
	word  progInst [maxEntries];
	int   progTest [maxEntries];
	word  expWb [maxEntries];
	word  expAlu [maxEntries];
	word  expStore [maxEntries];
	word  expNextPc [maxEntries];
	logic expRw [maxEntries];
	logic expMw [maxEntries];
	logic expAluOk [maxEntries];
	logic expHalt [maxEntries];
	int   tableLen = 0;

	// architectural reference state
	word        modelRegs [32];
	logic [7:0] modelMem [4096];
	word        modelPc;
	logic       modelHalted;

	string testName [7];
	int    testChecks [7];
	int    testErrors [7];
	int    activeTest = 0;
	int    checkCount = 0;
	int    errorCount = 0;
	int    cycleCount = 0;
	int    timeoutLimit = 1000;

	rvCore #(
		.resetVector (resetVec),
		.memWords    (1024)
	) rvCore_i (
		.clk       (clk),
		.rstN      (rstN),
		.inst      (inst),
		.pc        (pc),
		.aluResult (aluResult),
		.wbData    (wbData),
		.storeData (storeData),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.halted    (halted)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			$display("timeout after %0d cycles, the instruction table did not finish", cycleCount);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic word encR(input int f7, input int f3, input int rd, input int rs1,
		input int rs2);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opOp};
	endfunction

	function automatic word encI(input opcode op, input int f3, input int rd, input int rs1,
		input int imm);
		word v;
		v = imm;
		return {v[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic word encS(input int f3, input int rs1, input int rs2, input int imm);
		word v;
		v = imm;
		return {v[11:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:0], opStore};
	endfunction

	function automatic word encB(input int f3, input int rs1, input int rs2, input int imm);
		word v;
		v = imm;
		return {v[12], v[10:5], rs2[4:0], rs1[4:0], f3[2:0], v[4:1], v[11], opBranch};
	endfunction

	function automatic word encU(input opcode op, input int rd, input int imm);
		word v;
		v = imm;
		return {v[19:0], rd[4:0], op};
	endfunction

	function automatic word encJ(input int rd, input int imm);
		word v;
		v = imm;
		return {v[20], v[10:1], v[11], v[19:12], rd[4:0], opJal};
	endfunction

	// RV32I integer result where alt picks sub or sra
	function automatic word refArith(input logic [2:0] f3, input word a, input word b,
		input logic alt);
		word r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) begin
					r = $signed(a) >>> b[4:0];
				end else begin
					r = a >> b[4:0];
				end
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	task automatic modelStep(input int n, input word ins);
		word        a;
		word        b;
		word        immI;
		word        immS;
		word        immB;
		word        addr;
		word        wb;
		word        alu;
		word        npc;
		logic [2:0] f3;
		logic       taken;
		logic       rw;
		logic       mw;
		logic       aluOk;
		int         idx;
		a = modelRegs[ins[19:15]];
		b = modelRegs[ins[24:20]];
		f3 = ins[14:12];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		wb = '0;
		alu = '0;
		rw = 1'b0;
		mw = 1'b0;
		aluOk = 1'b0;
		npc = modelPc + 32'd4;
		if (modelHalted) begin
			npc = modelPc;
		end else begin
			case (opcode'(ins[6:0]))
				opLui: begin
					wb = {ins[31:12], 12'b0};
					rw = 1'b1;
					alu = wb;
					aluOk = 1'b1;
				end
				opAuipc: begin
					wb = modelPc + {ins[31:12], 12'b0};
					rw = 1'b1;
					alu = wb;
					aluOk = 1'b1;
				end
				opJal: begin
					wb = modelPc + 32'd4;
					rw = 1'b1;
					npc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				opJalr: begin
					wb = modelPc + 32'd4;
					rw = 1'b1;
					alu = a + immI;
					aluOk = 1'b1;
					npc = alu & ~32'd1;
				end
				opBranch: begin
					case (f3)
						3'd0: taken = (a == b);
						3'd1: taken = (a != b);
						3'd4: taken = $signed(a) < $signed(b);
						3'd5: taken = $signed(a) >= $signed(b);
						3'd6: taken = a < b;
						default: taken = a >= b;
					endcase
					if (taken) begin
						npc = modelPc + immB;
					end
				end
				opLoad: begin
					addr = a + immI;
					idx = 32'(addrLo(addr));
					alu = addr;
					aluOk = 1'b1;
					case (f3)
						3'd0: wb = {{24{modelMem[idx][7]}}, modelMem[idx]};
						3'd1: wb = {{16{modelMem[idx+1][7]}}, modelMem[idx+1], modelMem[idx]};
						3'd4: wb = {24'b0, modelMem[idx]};
						3'd5: wb = {16'b0, modelMem[idx+1], modelMem[idx]};
						default: begin
							wb = {modelMem[idx+3], modelMem[idx+2], modelMem[idx+1], modelMem[idx]};
						end
					endcase
					rw = 1'b1;
				end
				opStore: begin
					addr = a + immS;
					idx = 32'(addrLo(addr));
					alu = addr;
					aluOk = 1'b1;
					for (int k = 0; k < (1 << f3[1:0]); k++) begin
						modelMem[idx+k] = b[k*8 +: 8];
					end
					mw = 1'b1;
				end
				opImm: begin
					wb = refArith(f3, a, immI, ins[30] && f3 == 3'd5);
					rw = 1'b1;
					alu = wb;
					aluOk = 1'b1;
				end
				opOp: begin
					wb = refArith(f3, a, b, ins[30]);
					rw = 1'b1;
					alu = wb;
					aluOk = 1'b1;
				end
				opSystem: begin
					if (ins == ebreakInst) begin
						modelHalted = 1'b1;
						npc = modelPc;
					end
				end
				default: begin
					rw = 1'b0;
				end
			endcase
		end
		expWb[n] = wb;
		expAlu[n] = alu;
		expAluOk[n] = aluOk;
		expStore[n] = b;
		expRw[n] = rw;
		expMw[n] = mw;
		expHalt[n] = modelHalted;
		expNextPc[n] = npc;
		if (rw && ins[11:7] != 5'd0) begin
			modelRegs[ins[11:7]] = wb;
		end
		modelPc = npc;
	endtask

	// byte offset within the 4 KiB data array
	function automatic logic [11:0] addrLo(input word addr);
		return addr[11:0];
	endfunction

	task automatic addEntry(input int test, input word ins);
		progTest[tableLen] = test;
		progInst[tableLen] = ins;
		modelStep(tableLen, ins);
		tableLen++;
	endtask

	task automatic buildProgram();
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		for (int m = 0; m < 4096; m++) begin
			modelMem[m] = '0;
		end
		modelPc = resetVec;
		modelHalted = 1'b0;
		addEntry(2, encI(opImm, 0, 1, 0, 100));
		addEntry(2, encI(opImm, 0, 2, 0, -7));
		addEntry(2, encR(0, 0, 3, 1, 2));
		addEntry(2, encR(32, 0, 4, 2, 1));
		addEntry(2, encI(opImm, 4, 5, 1, 'h0f5));
		addEntry(2, encI(opImm, 6, 6, 2, 'h030));
		addEntry(2, encI(opImm, 7, 7, 2, 'h07f));
		addEntry(2, encI(opImm, 2, 8, 2, 1));
		addEntry(2, encI(opImm, 3, 9, 2, 1));
		addEntry(2, encI(opImm, 1, 10, 2, 3));
		addEntry(2, encI(opImm, 5, 11, 2, 4));
		addEntry(2, encI(opImm, 5, 12, 2, 'h402));
		addEntry(2, encR(0, 1, 13, 1, 1));
		addEntry(2, encR(0, 5, 14, 2, 1));
		addEntry(2, encR(32, 5, 15, 2, 1));
		addEntry(2, encR(0, 2, 16, 2, 1));
		addEntry(2, encR(0, 3, 17, 2, 1));
		addEntry(2, encR(0, 4, 18, 1, 2));
		addEntry(2, encR(0, 6, 19, 1, 2));
		addEntry(2, encR(0, 7, 20, 1, 2));
		// write to x0, then read it back
		addEntry(2, encI(opImm, 0, 0, 1, 5));
		addEntry(2, encR(0, 0, 21, 0, 0));
		addEntry(3, encU(opLui, 22, 'h12345));
		addEntry(3, encU(opAuipc, 23, 'h00010));
		addEntry(3, encJ(24, 16));
		addEntry(3, encI(opImm, 0, 25, 0, 'h300));
		addEntry(3, encI(opJalr, 0, 26, 25, -4));
		// each kind taken, then not taken
		addEntry(4, encB(0, 1, 1, 8));
		addEntry(4, encB(0, 1, 2, 8));
		addEntry(4, encB(1, 1, 2, -12));
		addEntry(4, encB(1, 1, 1, -12));
		addEntry(4, encB(4, 2, 1, 16));
		addEntry(4, encB(4, 1, 2, 16));
		addEntry(4, encB(5, 1, 2, 20));
		addEntry(4, encB(5, 2, 1, 20));
		addEntry(4, encB(6, 1, 2, -8));
		addEntry(4, encB(6, 2, 1, -8));
		addEntry(4, encB(7, 2, 1, 12));
		addEntry(4, encB(7, 1, 2, 12));
		addEntry(5, encI(opImm, 0, 27, 0, 'h100));
		addEntry(5, encU(opLui, 28, 'h89abd));
		addEntry(5, encI(opImm, 0, 28, 28, -529));
		addEntry(5, encS(2, 27, 28, 0));
		addEntry(5, encS(2, 27, 28, 4));
		addEntry(5, encS(0, 27, 2, 1));
		addEntry(5, encS(1, 27, 1, 6));
		addEntry(5, encI(opLoad, 2, 29, 27, 0));
		addEntry(5, encI(opLoad, 0, 30, 27, 1));
		addEntry(5, encI(opLoad, 4, 31, 27, 1));
		addEntry(5, encI(opLoad, 1, 29, 27, 2));
		addEntry(5, encI(opLoad, 5, 30, 27, 2));
		addEntry(5, encI(opLoad, 1, 31, 27, 6));
		addEntry(5, encI(opLoad, 0, 29, 27, 3));
		addEntry(5, encI(opLoad, 4, 30, 27, 7));
		addEntry(6, ebreakInst);
		addEntry(6, encI(opImm, 0, 5, 0, 1));
		addEntry(6, encS(2, 27, 28, 0));
		addEntry(6, encJ(1, 8));
		addEntry(6, encB(0, 0, 0, 8));
	endtask

	task automatic checkWord(input string what, input word actual, input word expected);
		checkCount++;
		testChecks[activeTest]++;
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
			errorCount++;
			testErrors[activeTest]++;
		end
	endtask

	task automatic checkFlag(input string what, input logic actual, input logic expected);
		checkCount++;
		testChecks[activeTest]++;
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, actual, expected);
			errorCount++;
			testErrors[activeTest]++;
		end
	endtask

	task automatic reportTest(input int id);
		$display("test %0d (%s): %0d checks, %0d errors", id, testName[id], testChecks[id],
			testErrors[id]);
	endtask

	initial begin
		int assertFails;
		clk = 1'b0;
		rstN = 1'b0;
		inst = encI(opImm, 0, 1, 0, 1);
		testName[1] = "reset";
		testName[2] = "arithmetic and logic";
		testName[3] = "upper immediates and jumps";
		testName[4] = "branches";
		testName[5] = "loads and stores";
		testName[6] = "ebreak halt";
		buildProgram();
		timeoutLimit = tableLen + 16 + 20;
		activeTest = 1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		checkWord("pc in reset", pc, resetVec);
		checkFlag("regWrite in reset", regWrite, 1'b0);
		checkFlag("memWrite in reset", memWrite, 1'b0);
		@(posedge clk);
		#10;
		inst = encS(2, 0, 1, 0);
		@(negedge clk);
		checkFlag("memWrite for store in reset", memWrite, 1'b0);
		repeat (7) @(posedge clk);
		#10;
		rstN = 1'b1;
		checkWord("pc after reset", pc, resetVec);
		reportTest(1);
		for (int i = 0; i < tableLen; i++) begin
			if (i > 0 && progTest[i] != progTest[i-1]) begin
				reportTest(progTest[i-1]);
			end
			activeTest = progTest[i];
			inst = progInst[i];
			@(negedge clk);
			checkFlag($sformatf("entry %0d regWrite", i), regWrite, expRw[i]);
			checkFlag($sformatf("entry %0d memWrite", i), memWrite, expMw[i]);
			checkFlag($sformatf("entry %0d halted", i), halted, expHalt[i]);
			if (expRw[i]) begin
				checkWord($sformatf("entry %0d wbData", i), wbData, expWb[i]);
			end
			if (expAluOk[i]) begin
				checkWord($sformatf("entry %0d aluResult", i), aluResult, expAlu[i]);
			end
			if (expMw[i]) begin
				checkWord($sformatf("entry %0d storeData", i), storeData, expStore[i]);
			end
			@(posedge clk);
			#10;
			checkWord($sformatf("entry %0d next pc", i), pc, expNextPc[i]);
		end
		reportTest(progTest[tableLen-1]);
		assertFails = rvCore_i.coreChecker_i.failCount;
		$display("%0d checks, %0d errors, %0d assertion failures", checkCount, errorCount,
			assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- vlog.f
common/rvPkg.sv
hdl/pcUnit.sv
decode/controlDecoder.sv
decode/immGenerator.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/dataMemory.sv
hdl/rvCore.sv
tb/rvCore_checker.sv
tb/rvCoreTb.sv
